// ==== src/lsd_params.svh ====
// macros for image size, counter widths and data widths
`ifndef LSD_PARAMS_SVH
`define LSD_PARAMS_SVH

// image size --------
`define LSD_IMAGE_WIDTH  8
`define LSD_IMAGE_HEIGHT 6

// counters ----------
// column count, enough for the image width
`define LSD_H_BITS       3
// row count
`define LSD_V_BITS       3

// data widths -------
`define LSD_PIXEL_BITS   8
// signed half-sum difference of two pixel pairs
`define LSD_GRAD_BITS    9
// gx^2 + gy^2 at the largest gradient
`define LSD_MAG_BITS     17
// octant code
`define LSD_DIR_BITS     3

`endif

// ==== src/lsd_pkg.sv ====
// package with pixel, coordinate, gradient, direction and stage payload types
`include "lsd_params.svh"

package lsd_pkg;

   // scalar types ------
   typedef logic [`LSD_PIXEL_BITS-1:0]       pixel_t;
   typedef logic [`LSD_H_BITS-1:0]           hcnt_t;
   typedef logic [`LSD_V_BITS-1:0]           vcnt_t;
   typedef logic signed [`LSD_GRAD_BITS-1:0] grad_t;
   typedef logic [`LSD_MAG_BITS-1:0]         mag2_t;
   // 0 to 7, counter-clockwise from +x
   typedef logic [`LSD_DIR_BITS-1:0]         dir_t;

   // stage payloads ----
   // 2x2 neighbourhood, p11 is the pixel just received
   typedef struct packed {
      pixel_t p00;
      pixel_t p01;
      pixel_t p10;
      pixel_t p11;
      vcnt_t  vcnt;
      hcnt_t  hcnt;
      // window lies fully inside the image
      logic   full;
   } window_t;

   typedef struct packed {
      grad_t gx;
      grad_t gy;
      vcnt_t vcnt;
      hcnt_t hcnt;
      logic  full;
   } grad_pix_t;

endpackage

// ==== src/lsd_stream_if.sv ====
// valid/ready stream interface with a payload type parameter and source/sink modports
interface lsd_stream_if #(
   parameter type payload_t = logic
);

   logic     valid;
   logic     ready;
   payload_t data;

   // producer side, holds valid and data until ready
   modport src (
      output valid,
      output data,
      input  ready
   );

   // consumer side
   modport snk (
      input  valid,
      input  data,
      output ready
   );

endinterface

// ==== src/window_2x2.sv ====
// module window_2x2, one-line pixel buffer forming the 2x2 window of each accepted pixel
`include "lsd_params.svh"

module window_2x2
   import lsd_pkg::*;
(
   input  logic      clock,
   input  logic      n_rst,
   input  logic      in_valid,
   input  pixel_t    in_pixel,
   input  vcnt_t     in_vcnt,
   input  hcnt_t     in_hcnt,
   output logic      in_ready,
   lsd_stream_if.src win
);

   // previous row, addressed by column
   pixel_t  line_buf [`LSD_IMAGE_WIDTH];
   // left neighbour and its upper neighbour
   pixel_t  prev_pix;
   pixel_t  prev_up;
   pixel_t  up_pix;
   logic    accept;
   window_t win_next;

   // handshake ---------
   // one item held, free when empty or drained this cycle
   assign in_ready = !win.valid || win.ready;
   assign accept   = in_valid && in_ready;

   // old value of the column, read before this pixel overwrites it
   assign up_pix = line_buf[in_hcnt];

   always_comb begin
      win_next.p00  = prev_up;
      win_next.p01  = up_pix;
      win_next.p10  = prev_pix;
      win_next.p11  = in_pixel;
      win_next.vcnt = in_vcnt;
      win_next.hcnt = in_hcnt;
      // first row and first column have no full neighbourhood
      win_next.full = (in_vcnt != '0) && (in_hcnt != '0);
   end

   // buffer and window registers
   always_ff @(posedge clock) begin
      if (accept) begin
         line_buf[in_hcnt] <= in_pixel;
         prev_pix          <= in_pixel;
         prev_up           <= up_pix;
         win.data          <= win_next;
      end
   end

   always_ff @(posedge clock) begin
      if (!n_rst) begin
         win.valid <= 1'b0;
      end else if (in_ready) begin
         win.valid <= in_valid;
      end
   end

   // checks ------------
   // source counts inside the image, or the buffer address wraps
   a_coord_range : assert property (@(posedge clock) disable iff (!n_rst)
      accept |-> (in_hcnt < `LSD_IMAGE_WIDTH) && (in_vcnt < `LSD_IMAGE_HEIGHT));

endmodule

// ==== src/gradient_calc.sv ====
// module gradient_calc, 2x2 differential filter giving signed horizontal and vertical gradients
`include "lsd_params.svh"

module gradient_calc
   import lsd_pkg::*;
(
   input  logic      clock,
   input  logic      n_rst,
   lsd_stream_if.snk win,
   lsd_stream_if.src grad
);

   // pair sums, one bit wider than the gradient
   logic [`LSD_GRAD_BITS:0]        sum_left;
   logic [`LSD_GRAD_BITS:0]        sum_right;
   logic [`LSD_GRAD_BITS:0]        sum_upper;
   logic [`LSD_GRAD_BITS:0]        sum_lower;
   logic signed [`LSD_GRAD_BITS:0] diff_h;
   logic signed [`LSD_GRAD_BITS:0] diff_v;
   logic                           accept;
   grad_pix_t                      grad_next;

   // handshake ---------
   assign win.ready = !grad.valid || grad.ready;
   assign accept    = win.valid && win.ready;

   // filter ------------
   always_comb begin
      sum_left  = {2'b00, win.data.p00} + {2'b00, win.data.p10};
      sum_right = {2'b00, win.data.p01} + {2'b00, win.data.p11};
      sum_upper = {2'b00, win.data.p00} + {2'b00, win.data.p01};
      sum_lower = {2'b00, win.data.p10} + {2'b00, win.data.p11};

      diff_h = $signed(sum_right) - $signed(sum_left);
      diff_v = $signed(sum_lower) - $signed(sum_upper);

      // halving keeps the result within the gradient range
      grad_next.gx   = grad_t'(diff_h >>> 1);
      grad_next.gy   = grad_t'(diff_v >>> 1);
      grad_next.vcnt = win.data.vcnt;
      grad_next.hcnt = win.data.hcnt;
      grad_next.full = win.data.full;
   end

   always_ff @(posedge clock) begin
      if (accept) begin
         grad.data <= grad_next;
      end
   end

   always_ff @(posedge clock) begin
      if (!n_rst) begin
         grad.valid <= 1'b0;
      end else if (win.ready) begin
         grad.valid <= win.valid;
      end
   end

   // checks ------------
   // a stalled window stays offered unchanged
   a_win_hold : assert property (@(posedge clock) disable iff (!n_rst)
      win.valid && !win.ready |=> win.valid && $stable(win.data));

endmodule

// ==== src/edge_classify.sv ====
// module edge_classify, squared magnitude threshold, octant direction and output register
`include "lsd_params.svh"

module edge_classify
   import lsd_pkg::*;
(
   input  logic      clock,
   input  logic      n_rst,
   lsd_stream_if.snk grad,
   input  mag2_t     grad_thres,
   output logic      out_valid,
   output logic      out_edge,
   output dir_t      out_dir,
   output vcnt_t     out_vcnt,
   output hcnt_t     out_hcnt,
   input  logic      out_ready
);

   logic [`LSD_GRAD_BITS-1:0] gx_abs;
   logic [`LSD_GRAD_BITS-1:0] gy_abs;
   mag2_t                     mag2;
   logic                      gx_pos;
   logic                      gx_neg;
   // angle within [0, 180)
   logic                      upper;
   logic                      is_edge;
   dir_t                      octant;
   logic                      accept;

   assign grad.ready = !out_valid || out_ready;
   assign accept     = grad.valid && grad.ready;

   // magnitude ---------
   always_comb begin
      gx_abs = grad.data.gx[`LSD_GRAD_BITS-1] ? -grad.data.gx : grad.data.gx;
      gy_abs = grad.data.gy[`LSD_GRAD_BITS-1] ? -grad.data.gy : grad.data.gy;
      mag2   = mag2_t'(gx_abs) * mag2_t'(gx_abs) + mag2_t'(gy_abs) * mag2_t'(gy_abs);
      is_edge = grad.data.full && (mag2 >= grad_thres);
   end

   // direction ---------
   // a tie on |gx| == |gy| goes to the lower octant
   always_comb begin
      gx_neg = grad.data.gx[`LSD_GRAD_BITS-1];
      gx_pos = !gx_neg && (grad.data.gx != '0);
      upper  = !grad.data.gy[`LSD_GRAD_BITS-1] && ((grad.data.gy != '0) || !gx_neg);
      if (upper) begin
         if (gx_pos) begin
            octant = (gy_abs <= gx_abs) ? 3'd0 : 3'd1;
         end else begin
            octant = (gy_abs >= gx_abs) ? 3'd2 : 3'd3;
         end
      end else begin
         if (gx_neg) begin
            octant = (gy_abs <= gx_abs) ? 3'd4 : 3'd5;
         end else begin
            octant = (gy_abs >= gx_abs) ? 3'd6 : 3'd7;
         end
      end
   end

   // output stage
   always_ff @(posedge clock) begin
      if (accept) begin
         out_edge <= is_edge;
         out_dir  <= is_edge ? octant : '0;
         out_vcnt <= grad.data.vcnt;
         out_hcnt <= grad.data.hcnt;
      end
   end

   always_ff @(posedge clock) begin
      if (!n_rst) begin
         out_valid <= 1'b0;
      end else if (grad.ready) begin
         out_valid <= grad.valid;
      end
   end

   // offered gradient is withdrawn only through a transfer
   a_grad_hold : assert property (@(posedge clock) disable iff (!n_rst)
      grad.valid && !grad.ready |=> grad.valid && $stable(grad.data));

endmodule

// ==== src/edge_front_top.sv ====
// module edge_front_top, edge detector front end with window, gradient and classify stages
module edge_front_top
   import lsd_pkg::*;
(
   input  logic   clock,
   input  logic   n_rst,
   // pixel stream in raster order
   input  logic   in_valid,
   input  pixel_t in_pixel,
   input  vcnt_t  in_vcnt,
   input  hcnt_t  in_hcnt,
   output logic   in_ready,
   // constant over a frame
   input  mag2_t  in_grad_thres,
   // edge stream
   output logic   out_valid,
   output logic   out_edge,
   output dir_t   out_dir,
   output vcnt_t  out_vcnt,
   output hcnt_t  out_hcnt,
   input  logic   out_ready
);

   // stage links -------
   lsd_stream_if #(.payload_t(window_t))   win_s ();
   lsd_stream_if #(.payload_t(grad_pix_t)) grad_s ();

   window_2x2 i_window (
      .clock    (clock),
      .n_rst    (n_rst),
      .in_valid (in_valid),
      .in_pixel (in_pixel),
      .in_vcnt  (in_vcnt),
      .in_hcnt  (in_hcnt),
      .in_ready (in_ready),
      .win      (win_s.src)
   );

   gradient_calc i_gradient (
      .clock (clock),
      .n_rst (n_rst),
      .win   (win_s.snk),
      .grad  (grad_s.src)
   );

   edge_classify i_classify (
      .clock      (clock),
      .n_rst      (n_rst),
      .grad       (grad_s.snk),
      .grad_thres (in_grad_thres),
      .out_valid  (out_valid),
      .out_edge   (out_edge),
      .out_dir    (out_dir),
      .out_vcnt   (out_vcnt),
      .out_hcnt   (out_hcnt),
      .out_ready  (out_ready)
   );

endmodule

// ==== testbench/tb_edge_front.sv ====
// testbench for the edge front end, file-driven frames, back-pressure and result checks
`include "lsd_params.svh"

module tb_edge_front
   import lsd_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int FRAME_PIXELS   = `LSD_IMAGE_WIDTH * `LSD_IMAGE_HEIGHT;
   // threshold word plus one word per pixel
   localparam int FRAME_WORDS    = FRAME_PIXELS + 1;
   localparam int FILE_FRAMES    = 4;
   // frames fed over all tests
   localparam int RUN_FRAMES     = 6;
   localparam int TIMEOUT_CYCLES = RUN_FRAMES * FRAME_PIXELS * 10 + 100;

   logic   clock;
   logic   n_rst;
   logic   in_valid;
   pixel_t in_pixel;
   vcnt_t  in_vcnt;
   hcnt_t  in_hcnt;
   logic   in_ready;
   mag2_t  in_grad_thres;
   logic   out_valid;
   logic   out_edge;
   dir_t   out_dir;
   vcnt_t  out_vcnt;
   hcnt_t  out_hcnt;
   logic   out_ready;

   // row, column, pixel, {edge, dir}
   logic [19:0] pattern_mem [FILE_FRAMES * FRAME_WORDS];
   logic [19:0] expect_q [$];
   logic [19:0] exp_word;
   int          cycle_cnt = 0;
   int          test_errors = 0;
   int          pass_cnt = 0;
   int          fail_cnt = 0;
   int          first_in_cycle = 0;
   int          first_out_cycle = -1;
   logic        stress = 1'b0;

   edge_front_top i_dut (.*);

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   always @(posedge clock) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial begin
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("timeout after %0d cycles, the output stream stopped", cycle_cnt);
      $display("TEST FAIL");
      $finish;
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
         test_errors++;
      end
   endtask

   task automatic report_test(input string name);
      if (test_errors == 0) begin
         pass_cnt++;
         $display("test %s: passed", name);
      end else begin
         fail_cnt++;
         $display("test %s: failed with %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   // output side --------
   // each transfer is matched with the oldest outstanding pixel
   always @(posedge clock) begin
      if (out_valid && out_ready) begin
         if (first_out_cycle < 0) begin
            first_out_cycle = cycle_cnt;
         end
         if (expect_q.size() == 0) begin
            $display("unexpected output at %0d ns with no pixel outstanding", $time);
            test_errors++;
         end else begin
            exp_word = expect_q.pop_front();
            check_value("out_vcnt", out_vcnt, exp_word[18:16]);
            check_value("out_hcnt", out_hcnt, exp_word[14:12]);
            check_value("out_edge", out_edge, exp_word[3]);
            check_value("out_dir", out_dir, exp_word[2:0]);
         end
      end
      out_ready <= stress ? ($urandom_range(3, 0) != 0) : 1'b1;
   end

   // input side ---------
   task automatic feed_frame(input int base, input bit gaps);
      logic [19:0] word;
      int          gap;
      for (int i = 0; i < FRAME_PIXELS; i++) begin
         word = pattern_mem[base + 1 + i];
         if (gaps) begin
            gap = $urandom_range(2, 0);
            repeat (gap) begin
               in_valid <= 1'b0;
               @(posedge clock);
            end
         end
         in_valid <= 1'b1;
         in_vcnt  <= word[18:16];
         in_hcnt  <= word[14:12];
         in_pixel <= word[11:4];
         // pixel stays offered until an edge with in_ready
         do begin
            @(posedge clock);
         end while (!in_ready);
         if (i == 0) begin
            first_in_cycle = cycle_cnt;
         end
      end
      in_valid <= 1'b0;
   endtask

   task automatic run_frame(input string name, input int frame, input bit stressed,
                            input bit check_latency);
      int base;
      base = frame * FRAME_WORDS;
      @(posedge clock);
      stress         <= stressed;
      first_out_cycle = -1;
      in_grad_thres  <= pattern_mem[base][`LSD_MAG_BITS-1:0];
      for (int i = 0; i < FRAME_PIXELS; i++) begin
         expect_q.push_back(pattern_mem[base + 1 + i]);
      end
      feed_frame(base, stressed);
      while (expect_q.size() != 0) begin
         @(posedge clock);
      end
      // room for a stray extra output
      repeat (4) @(posedge clock);
      if (check_latency) begin
         check_value("first output latency", first_out_cycle - first_in_cycle, 3);
      end
      report_test(name);
   endtask

   initial begin
      void'($urandom(32'hde4));
      $readmemh("testbench/edge_patterns.dat", pattern_mem);
      n_rst         <= 1'b0;
      in_valid      <= 1'b0;
      in_pixel      <= '0;
      in_vcnt       <= '0;
      in_hcnt       <= '0;
      in_grad_thres <= '0;
      out_ready     <= 1'b1;

      // reset over four edges, outputs settled from the second one
      for (int k = 0; k < 7; k++) begin
         @(posedge clock);
         if (k == 3) begin
            n_rst <= 1'b1;
         end
         if (k > 0) begin
            check_value("out_valid", out_valid, 1'b0);
            check_value("in_ready", in_ready, 1'b1);
         end
      end
      report_test("reset");

      run_frame("flat frame and latency", 0, 1'b0, 1'b1);
      run_frame("step directions", 1, 1'b0, 1'b0);
      run_frame("ramp directions", 2, 1'b0, 1'b0);
      run_frame("ramps at high threshold", 3, 1'b0, 1'b0);
      run_frame("steps under back-pressure", 1, 1'b1, 1'b0);
      run_frame("ramps under back-pressure", 2, 1'b1, 1'b0);

      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+src
src/lsd_pkg.sv
src/lsd_stream_if.sv
src/window_2x2.sv
src/gradient_calc.sv
src/edge_classify.sv
src/edge_front_top.sv
testbench/tb_edge_front.sv

// ==== testbench/edge_patterns.dat ====
// per frame one threshold word, then 48 words RCPPE in raster order
// R row, C column, PP pixel, E expected {edge, dir}
00100 // frame 0, flat
00550 01550 02550 03550 04550 05550 06550 07550
10550 11550 12550 13550 14550 15550 16550 17550
20550 21550 22550 23550 24550 25550 26550 27550
30550 31550 32550 33550 34550 35550 36550 37550
40550 41550 42550 43550 44550 45550 46550 47550
50550 51550 52550 53550 54550 55550 56550 57550
00100 // frame 1, vertical and horizontal steps of both polarities
00000 01000 02000 03000 04800 05800 06800 07800
10000 11000 12000 13000 14808 15800 16800 17800
20000 21000 22000 23000 24808 25800 26800 27800
30800 3180a 3280a 3380a 34000 3500e 3600e 3700e
40800 41800 42800 43800 4400c 45000 46000 47000
50800 51800 52800 53800 5400c 55000 56000 57000
00100 // frame 2, ramps covering all eight octants
00200 01300 02500 03500 04400 05200 06300 07300
10300 11408 12608 1360a 1450a 1530b 16408 1740a
20500 21609 22808 2380a 2470a 2550a 26609 2760a
30400 3150e 3270f 3370e 3460c 3540c 3650e 3750e
40200 4130e 4250e 4350e 4440d 4520c 4630e 4730e
50200 51308 52508 53500 5440c 5520c 56308 57300
00500 // frame 3, ramps again at a high threshold
00200 01300 02500 03500 04400 05200 06300 07300
10300 11400 12608 13600 14500 1530b 16400 17400
20500 21609 22808 23800 2470a 2550a 26609 27600
30400 31500 3270f 33700 34600 3540c 36500 37500
40200 4130e 4250e 43500 4440d 4520c 4630e 47300
50200 51300 52500 53500 54400 55200 56300 57300
